// ==== Bender.yml ====
package:
  name: rx_frontend

sources:
  - src/rx_pkg.sv
  - src/cfo_phase_accumulator.sv
  - src/quadrant_derotator.sv
  - src/pbch_llr_fifo.sv
  - src/rx_regmap.sv
  - src/rx_frontend.sv
  - target: test
    files:
      - verification/rx_frontend_checker.sv
      - verification/tb_rx_frontend.sv

// ==== filelist.f ====
src/rx_pkg.sv
src/cfo_phase_accumulator.sv
src/quadrant_derotator.sv
src/pbch_llr_fifo.sv
src/rx_regmap.sv
src/rx_frontend.sv
verification/rx_frontend_checker.sv
verification/tb_rx_frontend.sv

// ==== src/cfo_phase_accumulator.sv ====
`timescale 1ns/100ps

module cfo_phase_accumulator import rx_pkg::*; (
    input  logic                       clk_i,
    input  logic                       reset_ni,

    input  logic                       cfo_mode_i,
    input  logic signed [PHASE_DW-1:0] cfo_inc_i,
    input  logic                       cfo_valid_i,
    input  logic                       sample_valid_i,

    output logic        [PHASE_DW-1:0] phase_o
);

    logic signed [PHASE_DW-1:0] inc_acc;
    logic        [PHASE_DW-1:0] phase;

    // ------------------------------------------------------------
    // increment and phase, both from the old values of the cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            inc_acc <= '0;
            phase   <= '0;
        end else if (cfo_mode_i) begin
            // manual mode holds everything at zero
            inc_acc <= '0;
            phase   <= '0;
        end else begin
            // corrections are relative to the previous one
            if (cfo_valid_i) begin
                inc_acc <= inc_acc - cfo_inc_i;
            end
            if (sample_valid_i) begin
                phase <= phase + inc_acc;
            end
        end
    end

    assign phase_o = phase;

    // ------------------------------------------------------------
    // manual mode pins the phase seen by the derotator
    a_manual_phase_zero : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        cfo_mode_i |=> (phase_o == '0)
    ) else $error("phase not zero in manual CFO mode");

endmodule

// ==== src/pbch_llr_fifo.sv ====
`timescale 1ns/100ps

module pbch_llr_fifo import rx_pkg::*; (
    input  logic                    clk_i,
    input  logic                    reset_ni,

    input  llr_t                    llr_i,
    input  llr_type_t               llr_type_i,
    input  logic                    llr_valid_i,

    input  logic                    pop_i,
    input  logic                    clear_i,

    output llr_t                    head_o,
    output logic [LLR_LEVEL_DW-1:0] level_o,
    output logic                    overflow_o
);

    localparam int PTR_DW = $clog2(LLR_FIFO_DEPTH);

    llr_t                    llr_mem [LLR_FIFO_DEPTH];
    logic [PTR_DW-1:0]       wr_ptr;
    logic [PTR_DW-1:0]       rd_ptr;
    logic [LLR_LEVEL_DW-1:0] level;
    logic                    is_pbch;
    logic                    full;
    logic                    push;

    assign is_pbch = llr_valid_i && (llr_type_i == LLR_TYPE_PBCH);
    assign full    = (level == LLR_LEVEL_DW'(LLR_FIFO_DEPTH));
    // full buffer drops the new entry, even with a pop in the same cycle
    assign push    = is_pbch && !full;

    always_ff @(posedge clk_i) begin
        if (push) begin
            llr_mem[wr_ptr] <= llr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            level      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + LLR_LEVEL_DW'(push) - LLR_LEVEL_DW'(pop_i);
            if (is_pbch && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    assign head_o  = llr_mem[rd_ptr];
    assign level_o = level;

    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        pop_i |-> (level != '0)
    ) else $error("pop on empty LLR buffer");

endmodule

// ==== src/quadrant_derotator.sv ====
`timescale 1ns/100ps

module quadrant_derotator import rx_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  iq_sample_t          sample_i,
    input  logic                sample_valid_i,
    input  logic [PHASE_DW-1:0] phase_i,

    output iq_sample_t          rot_sample_o,
    output logic                rot_valid_o
);

    logic [1:0] quadrant;
    iq_sample_t rot_next;

    // -32768 has no positive counterpart
    function automatic logic signed [IQ_HALF_DW-1:0] neg_sat(
        input logic signed [IQ_HALF_DW-1:0] x
    );
        logic signed [IQ_HALF_DW-1:0] min_val;
        min_val = {1'b1, {(IQ_HALF_DW-1){1'b0}}};
        if (x == min_val) begin
            return ~min_val;
        end
        return -x;
    endfunction

    assign quadrant = phase_i[PHASE_DW-1 -: 2];

    // multiply by j^k
    always_comb begin
        case (quadrant)
            2'd0: begin
                rot_next.i = sample_i.i;
                rot_next.q = sample_i.q;
            end
            2'd1: begin
                rot_next.i = neg_sat(sample_i.q);
                rot_next.q = sample_i.i;
            end
            2'd2: begin
                rot_next.i = neg_sat(sample_i.i);
                rot_next.q = neg_sat(sample_i.q);
            end
            default: begin
                rot_next.i = sample_i.q;
                rot_next.q = neg_sat(sample_i.i);
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            rot_sample_o <= rot_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rot_valid_o <= 1'b0;
        end else begin
            rot_valid_o <= sample_valid_i;
        end
    end

    a_valid_latency : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        $past(reset_ni) |-> (rot_valid_o == $past(sample_valid_i))
    ) else $error("rot_valid_o does not follow sample_valid_i by one cycle");

endmodule

// ==== src/rx_frontend.sv ====
`timescale 1ns/100ps

module rx_frontend import rx_pkg::*; (
    input  logic                       clk_i,
    input  logic                       reset_ni,

    // sample stream
    input  iq_sample_t                 sample_i,
    input  logic                       sample_valid_i,
    output iq_sample_t                 rot_sample_o,
    output logic                       rot_valid_o,

    // detector results
    input  logic signed [PHASE_DW-1:0] cfo_inc_i,
    input  logic                       cfo_valid_i,
    input  logic        [N_ID_DW-1:0]  n_id_i,
    input  logic                       n_id_valid_i,

    // demapper llrs
    input  llr_t                       llr_i,
    input  llr_type_t                  llr_type_i,
    input  logic                       llr_valid_i,

    // register bus
    input  logic [REG_ADDR_DW-1:0]     reg_addr_i,
    input  logic                       reg_read_i,
    input  logic                       reg_write_i,
    input  logic [REG_DW-1:0]          reg_wdata_i,
    output logic [REG_DW-1:0]          reg_rdata_o,
    output logic                       reg_rvalid_o
);

    logic                    cfo_mode;
    logic [PHASE_DW-1:0]     phase;
    logic                    llr_pop;
    logic                    llr_clear;
    llr_t                    llr_head;
    logic [LLR_LEVEL_DW-1:0] llr_level;
    logic                    llr_overflow;

    // ------------------------------------------------------------
    // sample path
    cfo_phase_accumulator cfo_phase_accumulator_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .cfo_mode_i     (cfo_mode),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .sample_valid_i (sample_valid_i),
        .phase_o        (phase)
    );

    quadrant_derotator quadrant_derotator_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .phase_i        (phase),
        .rot_sample_o   (rot_sample_o),
        .rot_valid_o    (rot_valid_o)
    );

    // ------------------------------------------------------------
    // llr buffer and registers
    pbch_llr_fifo pbch_llr_fifo_inst (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .llr_i       (llr_i),
        .llr_type_i  (llr_type_i),
        .llr_valid_i (llr_valid_i),
        .pop_i       (llr_pop),
        .clear_i     (llr_clear),
        .head_o      (llr_head),
        .level_o     (llr_level),
        .overflow_o  (llr_overflow)
    );

    rx_regmap rx_regmap_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .reg_addr_i     (reg_addr_i),
        .reg_read_i     (reg_read_i),
        .reg_write_i    (reg_write_i),
        .reg_wdata_i    (reg_wdata_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .llr_head_i     (llr_head),
        .llr_level_i    (llr_level),
        .llr_overflow_i (llr_overflow),
        .reg_rdata_o    (reg_rdata_o),
        .reg_rvalid_o   (reg_rvalid_o),
        .cfo_mode_o     (cfo_mode),
        .llr_pop_o      (llr_pop),
        .llr_clear_o    (llr_clear)
    );

endmodule

// ==== src/rx_pkg.sv ====
package rx_pkg;

    // ------------------------------------------------------------
    // sample path
    localparam int IQ_DW      = 32;
    localparam int IQ_HALF_DW = IQ_DW / 2;
    localparam int PHASE_DW   = 20;

    // I in the low half, Q in the high half
    typedef struct packed {
        logic signed [IQ_HALF_DW-1:0] q;
        logic signed [IQ_HALF_DW-1:0] i;
    } iq_sample_t;

    // ------------------------------------------------------------
    // pbch llr buffer
    localparam int LLR_DW         = 8;
    localparam int LLR_TYPE_DW    = 2;
    localparam int LLR_FIFO_DEPTH = 16;
    localparam int LLR_LEVEL_DW   = $clog2(LLR_FIFO_DEPTH) + 1;
    localparam int LLR_OVF_BIT    = 16;

    typedef logic [LLR_DW-1:0]      llr_t;
    typedef logic [LLR_TYPE_DW-1:0] llr_type_t;

    localparam llr_type_t LLR_TYPE_PBCH = 2'd1;

    // ------------------------------------------------------------
    // register map
    localparam int N_ID_DW       = 10;
    localparam int SAMPLE_CNT_DW = 64;
    localparam int REG_ADDR_DW   = 4;
    localparam int REG_DW        = 32;

    localparam logic [REG_ADDR_DW-1:0] ADDR_CTRL        = 4'd0;
    localparam logic [REG_ADDR_DW-1:0] ADDR_LAST_SAMPLE = 4'd1;
    localparam logic [REG_ADDR_DW-1:0] ADDR_N_ID        = 4'd2;
    localparam logic [REG_ADDR_DW-1:0] ADDR_CNT_LO      = 4'd3;
    localparam logic [REG_ADDR_DW-1:0] ADDR_CNT_HI      = 4'd4;
    localparam logic [REG_ADDR_DW-1:0] ADDR_LLR_LEVEL   = 4'd5;
    localparam logic [REG_ADDR_DW-1:0] ADDR_LLR_POP     = 4'd6;
    localparam logic [REG_ADDR_DW-1:0] ADDR_LLR_CLEAR   = 4'd7;

endpackage

// ==== src/rx_regmap.sv ====
`timescale 1ns/100ps

module rx_regmap import rx_pkg::*; (
    input  logic                    clk_i,
    input  logic                    reset_ni,

    input  logic [REG_ADDR_DW-1:0]  reg_addr_i,
    input  logic                    reg_read_i,
    input  logic                    reg_write_i,
    input  logic [REG_DW-1:0]       reg_wdata_i,

    input  iq_sample_t              sample_i,
    input  logic                    sample_valid_i,
    input  logic [N_ID_DW-1:0]      n_id_i,
    input  logic                    n_id_valid_i,

    input  llr_t                    llr_head_i,
    input  logic [LLR_LEVEL_DW-1:0] llr_level_i,
    input  logic                    llr_overflow_i,

    output logic [REG_DW-1:0]       reg_rdata_o,
    output logic                    reg_rvalid_o,
    output logic                    cfo_mode_o,
    output logic                    llr_pop_o,
    output logic                    llr_clear_o
);

    iq_sample_t               last_sample;
    logic [N_ID_DW-1:0]       n_id;
    logic [SAMPLE_CNT_DW-1:0] sample_cnt;
    logic [REG_DW-1:0]        rdata_next;

    // ------------------------------------------------------------
    // control and status registers
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_mode_o  <= 1'b0;
            last_sample <= '0;
            n_id        <= '0;
            sample_cnt  <= '0;
        end else begin
            if (reg_write_i && (reg_addr_i == ADDR_CTRL)) begin
                cfo_mode_o <= reg_wdata_i[0];
            end
            if (sample_valid_i) begin
                last_sample <= sample_i;
                sample_cnt  <= sample_cnt + 1'b1;
            end
            if (n_id_valid_i) begin
                n_id <= n_id_i;
            end
        end
    end

    assign llr_pop_o   = reg_read_i && (reg_addr_i == ADDR_LLR_POP) && (llr_level_i != '0);
    assign llr_clear_o = reg_write_i && (reg_addr_i == ADDR_LLR_CLEAR);

    // ------------------------------------------------------------
    // read mux, unknown addresses give zero
    always_comb begin
        rdata_next = '0;
        case (reg_addr_i)
            ADDR_CTRL:        rdata_next[0] = cfo_mode_o;
            ADDR_LAST_SAMPLE: rdata_next = last_sample;
            ADDR_N_ID:        rdata_next[N_ID_DW-1:0] = n_id;
            ADDR_CNT_LO:      rdata_next = sample_cnt[REG_DW-1:0];
            ADDR_CNT_HI:      rdata_next = sample_cnt[SAMPLE_CNT_DW-1 -: REG_DW];
            ADDR_LLR_LEVEL: begin
                rdata_next[LLR_LEVEL_DW-1:0] = llr_level_i;
                rdata_next[LLR_OVF_BIT]      = llr_overflow_i;
            end
            ADDR_LLR_POP: begin
                if (llr_level_i != '0) begin
                    rdata_next[LLR_DW-1:0] = llr_head_i;
                end
            end
            default:          rdata_next = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reg_read_i) begin
            reg_rdata_o <= rdata_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            reg_rvalid_o <= 1'b0;
        end else begin
            reg_rvalid_o <= reg_read_i;
        end
    end

    a_no_read_write : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !(reg_read_i && reg_write_i)
    ) else $error("register read and write in the same cycle");

endmodule

// ==== verification/rx_frontend_checker.sv ====
`timescale 1ns/100ps

module rx_frontend_checker import rx_pkg::*; (
    input  logic                       clk_i,
    input  logic                       reset_ni,

    input  iq_sample_t                 sample_i,
    input  logic                       sample_valid_i,
    input  iq_sample_t                 rot_sample_i,
    input  logic                       rot_valid_i,

    input  logic signed [PHASE_DW-1:0] cfo_inc_i,
    input  logic                       cfo_valid_i,
    input  logic        [N_ID_DW-1:0]  n_id_i,
    input  logic                       n_id_valid_i,

    input  llr_t                       llr_i,
    input  llr_type_t                  llr_type_i,
    input  logic                       llr_valid_i,

    input  logic [REG_ADDR_DW-1:0]     reg_addr_i,
    input  logic                       reg_read_i,
    input  logic                       reg_write_i,
    input  logic [REG_DW-1:0]          reg_wdata_i,
    input  logic [REG_DW-1:0]          reg_rdata_i,
    input  logic                       reg_rvalid_i,

    output int                         check_count_o,
    output int                         error_count_o
);

    // reference model state
    logic [19:0] m_phase;
    logic [19:0] m_inc;
    logic        m_mode;
    logic [31:0] m_last;
    logic [9:0]  m_n_id;
    logic [63:0] m_count;
    logic [7:0]  llr_q[$];
    logic        m_ovf;

    // expected outputs after the coming clock edge
    logic        exp_rot_valid;
    logic [31:0] exp_rot;
    logic        exp_rvalid;
    logic [31:0] exp_rdata;
    logic        armed;

    initial begin
        check_count_o = 0;
        error_count_o = 0;
        armed         = 1'b0;
    end

    function automatic logic [15:0] negate_clipped(input logic signed [15:0] x);
        int v;
        v = x;
        v = -v;
        if (v > 32767) begin
            v = 32767;
        end
        return v[15:0];
    endfunction

    // sample times j^k, I in the low half
    function automatic logic [31:0] quadrant_rotate(input logic [31:0] s, input logic [1:0] k);
        logic [15:0] si;
        logic [15:0] sq;
        logic [15:0] ri;
        logic [15:0] rq;
        si = s[15:0];
        sq = s[31:16];
        case (k)
            2'd0: begin
                ri = si;
                rq = sq;
            end
            2'd1: begin
                ri = negate_clipped(sq);
                rq = si;
            end
            2'd2: begin
                ri = negate_clipped(si);
                rq = negate_clipped(sq);
            end
            default: begin
                ri = sq;
                rq = negate_clipped(si);
            end
        endcase
        return {rq, ri};
    endfunction

    function automatic logic [31:0] register_value(input logic [3:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            4'd0: v[0] = m_mode;
            4'd1: v = m_last;
            4'd2: v[9:0] = m_n_id;
            4'd3: v = m_count[31:0];
            4'd4: v = m_count[63:32];
            4'd5: begin
                v[4:0] = llr_q.size();
                v[16]  = m_ovf;
            end
            4'd6: begin
                if (llr_q.size() != 0) begin
                    v[7:0] = llr_q[0];
                end
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] expected);
        error_count_o++;
        $display("MISMATCH at time %0t: %s got %h, expected %h", $time, what, got, expected);
    endtask

    // ----------------------------------------------------------
    // comparisons
    task automatic compare_outputs();
        check_count_o++;
        if (rot_valid_i !== exp_rot_valid) begin
            report_mismatch("rot_valid_o", 32'(rot_valid_i), 32'(exp_rot_valid));
        end else if (exp_rot_valid) begin
            check_count_o++;
            if (rot_sample_i !== exp_rot) begin
                report_mismatch("rot_sample_o", rot_sample_i, exp_rot);
            end
        end
        check_count_o++;
        if (reg_rvalid_i !== exp_rvalid) begin
            report_mismatch("reg_rvalid_o", 32'(reg_rvalid_i), 32'(exp_rvalid));
        end else if (exp_rvalid) begin
            check_count_o++;
            if (reg_rdata_i !== exp_rdata) begin
                report_mismatch("reg_rdata_o", reg_rdata_i, exp_rdata);
            end
        end
    endtask

    task automatic reset_model();
        m_phase       = '0;
        m_inc         = '0;
        m_mode        = 1'b0;
        m_last        = '0;
        m_n_id        = '0;
        m_count       = '0;
        m_ovf         = 1'b0;
        exp_rot_valid = 1'b0;
        exp_rvalid    = 1'b0;
        llr_q.delete();
    endtask

    // ----------------------------------------------------------
    // model step, inputs as the next rising edge sees them
    task automatic step_model();
        logic       was_full;
        logic [7:0] dropped;
        exp_rot_valid = sample_valid_i;
        if (sample_valid_i) begin
            exp_rot = quadrant_rotate(sample_i, m_phase[19:18]);
        end
        exp_rvalid = reg_read_i;
        if (reg_read_i) begin
            exp_rdata = register_value(reg_addr_i);
        end

        // full is judged before this cycle's pop
        was_full = (llr_q.size() == 16);
        if (reg_read_i && reg_addr_i == 4'd6 && llr_q.size() != 0) begin
            dropped = llr_q.pop_front();
        end
        if (llr_valid_i && llr_type_i == 2'd1) begin
            if (was_full) begin
                m_ovf = 1'b1;
            end else begin
                llr_q.push_back(llr_i);
            end
        end
        if (reg_write_i && reg_addr_i == 4'd7) begin
            llr_q.delete();
            m_ovf = 1'b0;
        end

        if (m_mode) begin
            m_phase = '0;
            m_inc   = '0;
        end else begin
            if (sample_valid_i) begin
                m_phase = m_phase + m_inc;
            end
            if (cfo_valid_i) begin
                m_inc = m_inc - cfo_inc_i;
            end
        end
        if (reg_write_i && reg_addr_i == 4'd0) begin
            m_mode = reg_wdata_i[0];
        end
        if (sample_valid_i) begin
            m_last  = sample_i;
            m_count = m_count + 1;
        end
        if (n_id_valid_i) begin
            m_n_id = n_id_i;
        end
    endtask

    // falling edge keeps clear of both the driver and the DUT registers
    always @(negedge clk_i) begin
        if (armed) begin
            compare_outputs();
        end
        if (!reset_ni) begin
            reset_model();
            armed = 1'b1;
        end else begin
            step_model();
        end
    end

endmodule

// ==== verification/tb_rx_frontend.sv ====
`timescale 1ns/100ps

module tb_rx_frontend import rx_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int READ_TIMEOUT = 8;
    localparam int MAX_CYCLES   = 20000;

    logic                       clk_i;
    logic                       reset_ni;
    iq_sample_t                 sample_i;
    logic                       sample_valid_i;
    iq_sample_t                 rot_sample_o;
    logic                       rot_valid_o;
    logic signed [PHASE_DW-1:0] cfo_inc_i;
    logic                       cfo_valid_i;
    logic        [N_ID_DW-1:0]  n_id_i;
    logic                       n_id_valid_i;
    llr_t                       llr_i;
    llr_type_t                  llr_type_i;
    logic                       llr_valid_i;
    logic [REG_ADDR_DW-1:0]     reg_addr_i;
    logic                       reg_read_i;
    logic                       reg_write_i;
    logic [REG_DW-1:0]          reg_wdata_i;
    logic [REG_DW-1:0]          reg_rdata_o;
    logic                       reg_rvalid_o;

    int          check_count;
    int          error_count;
    int          timeout_count;
    int          checks_at_start;
    int          errors_at_start;
    int          timeouts_at_start;
    int          pbch_sent;
    logic [31:0] lcg_state;

    rx_frontend rx_frontend_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .rot_sample_o   (rot_sample_o),
        .rot_valid_o    (rot_valid_o),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .llr_i          (llr_i),
        .llr_type_i     (llr_type_i),
        .llr_valid_i    (llr_valid_i),
        .reg_addr_i     (reg_addr_i),
        .reg_read_i     (reg_read_i),
        .reg_write_i    (reg_write_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rdata_o    (reg_rdata_o),
        .reg_rvalid_o   (reg_rvalid_o)
    );

    rx_frontend_checker rx_frontend_checker_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .rot_sample_i   (rot_sample_o),
        .rot_valid_i    (rot_valid_o),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .llr_i          (llr_i),
        .llr_type_i     (llr_type_i),
        .llr_valid_i    (llr_valid_i),
        .reg_addr_i     (reg_addr_i),
        .reg_read_i     (reg_read_i),
        .reg_write_i    (reg_write_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rdata_i    (reg_rdata_o),
        .reg_rvalid_i   (reg_rvalid_o),
        .check_count_o  (check_count),
        .error_count_o  (error_count)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // two LCG steps, upper halves only
    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi        = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi, lcg_state[31:16]};
    endfunction

    // sometimes the most negative value, to hit saturation
    function automatic logic [15:0] random_component();
        logic [31:0] r;
        r = rand32();
        if (r[31:29] == 3'd0) begin
            return 16'h8000;
        end
        return r[15:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    task automatic clear_strobes();
        sample_valid_i = 1'b0;
        cfo_valid_i    = 1'b0;
        n_id_valid_i   = 1'b0;
        llr_valid_i    = 1'b0;
        reg_read_i     = 1'b0;
        reg_write_i    = 1'b0;
    endtask

    // ----------------------------------------------------------
    // stimulus
    task automatic drive_samples(input int cycles, input bit with_cfo);
        logic [31:0] r;
        for (int n = 0; n < cycles; n++) begin
            r              = rand32();
            sample_valid_i = (r[31:29] != 3'd0);
            sample_i.i     = random_component();
            sample_i.q     = random_component();
            if (with_cfo && r[28:26] == 3'd0) begin
                cfo_valid_i = 1'b1;
                cfo_inc_i   = PHASE_DW'(rand32());
            end
            next_cycle();
            clear_strobes();
        end
    endtask

    task automatic drive_llrs(input int cycles);
        logic [31:0] r;
        for (int n = 0; n < cycles; n++) begin
            r           = rand32();
            llr_valid_i = (r[31:30] != 2'd0);
            llr_type_i  = r[29:28];
            llr_i       = r[7:0];
            if (llr_valid_i && llr_type_i == 2'd1) begin
                pbch_sent++;
            end
            next_cycle();
            clear_strobes();
        end
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        reg_addr_i  = addr;
        reg_wdata_i = data;
        reg_write_i = 1'b1;
        next_cycle();
        clear_strobes();
    endtask

    task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
        int waited;
        reg_addr_i = addr;
        reg_read_i = 1'b1;
        next_cycle();
        clear_strobes();
        waited = 0;
        while (!reg_rvalid_o && waited < READ_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!reg_rvalid_o) begin
            $display("timeout: no read response from register address %0d", addr);
            timeout_count++;
        end
        data = reg_rdata_o;
    endtask

    // read the level, then pop that many entries
    task automatic drain_llrs();
        logic [31:0] level;
        logic [31:0] data;
        reg_read(4'd5, level);
        for (int n = 0; n < level[4:0]; n++) begin
            reg_read(4'd6, data);
        end
    endtask

    task automatic start_test();
        checks_at_start   = check_count;
        errors_at_start   = error_count;
        timeouts_at_start = timeout_count;
    endtask

    task automatic end_test(input string name);
        next_cycle();
        next_cycle();
        $display("%s: %0d checks, %0d errors, %0d timeouts", name,
                 check_count - checks_at_start, error_count - errors_at_start,
                 timeout_count - timeouts_at_start);
    endtask

    // ----------------------------------------------------------
    // test sequence
    initial begin
        logic [31:0] data;
        int          n;
        lcg_state     = 32'd30;
        timeout_count = 0;
        pbch_sent     = 0;
        reset_ni      = 1'b0;
        sample_i      = '0;
        cfo_inc_i     = '0;
        n_id_i        = '0;
        llr_i         = '0;
        llr_type_i    = '0;
        reg_addr_i    = '0;
        reg_wdata_i   = '0;
        clear_strobes();
        repeat (10) @(posedge clk_i);
        #(DRIVE_DELAY);
        reset_ni = 1'b1;

        start_test();
        next_cycle();
        next_cycle();
        for (int a = 0; a < 9; a++) begin
            reg_read(4'(a), data);
        end
        reg_read(4'd12, data);
        end_test("reset");

        start_test();
        drive_samples(200, 1'b1);
        end_test("derotation");

        start_test();
        reg_write(4'd0, 32'd1);
        reg_read(4'd0, data);
        drive_samples(40, 1'b1);
        reg_write(4'd0, 32'd0);
        drive_samples(60, 1'b1);
        end_test("manual mode");

        start_test();
        drive_llrs(30);
        drain_llrs();
        pbch_sent = 0;
        n = 0;
        while (pbch_sent < 20 && n < 400) begin
            drive_llrs(1);
            n++;
        end
        if (pbch_sent < 20) begin
            $display("timeout: fewer than 20 PBCH LLRs were sent");
            timeout_count++;
        end
        drain_llrs();
        reg_read(4'd5, data);
        end_test("llr filtering");

        start_test();
        for (int k = 0; k < 4; k++) begin
            n_id_i       = N_ID_DW'(rand32());
            n_id_valid_i = 1'b1;
            next_cycle();
            clear_strobes();
            drive_samples(15, 1'b0);
            reg_read(4'd2, data);
            reg_read(4'd1, data);
            reg_read(4'd3, data);
            reg_read(4'd4, data);
        end
        end_test("latched values");

        start_test();
        drive_llrs(60);
        reg_read(4'd5, data);
        reg_write(4'd7, 32'd0);
        reg_read(4'd5, data);
        reg_read(4'd6, data);
        end_test("clear");

        $display("summary: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run limit
    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout: simulation did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule
